//--- bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// address width, word addressed so pc steps by 1
`define WORD_SIZE 16

// btb index width, 64 entries
`define BTB_IDX_SIZE 6

// tag width, whatever the index leaves over
`define TAG_SIZE (`WORD_SIZE - `BTB_IDX_SIZE)

// counter state after reset or install
`define BHT_INIT 2'b10 // weakly taken

`endif

//--- bp_pkg.sv
`include "bp_consts.svh"

package bp_pkg;

   // pc or branch target
   typedef logic [`WORD_SIZE-1:0] word_t;

   // low pc bits, select a table entry
   typedef logic [`BTB_IDX_SIZE-1:0] btb_idx_t;

   // high pc bits, compared against the stored tag
   typedef logic [`TAG_SIZE-1:0] tag_t;

   // 2-bit saturating history counter
   // taken side is the upper half, msb set
   typedef enum logic [1:0] {
      strong_not_taken = 2'b00,
      weak_not_taken   = 2'b01,
      weak_taken       = 2'b10,
      strong_taken     = 2'b11
   } bht_state_t;

endpackage

//--- branch_predictor.sv
`include "bp_consts.svh"

module branch_predictor (
   input  logic          clk,
   input  logic          reset_n,
   input  bp_pkg::word_t lookup_pc,     // current fetch pc
   input  logic          update_tag,    // install or rewrite tag and target
   input  logic          update_bht,    // train the counter
   input  bp_pkg::word_t update_pc,     // pc of the resolved branch
   input  logic          update_taken,  // resolved direction
   input  bp_pkg::word_t update_target, // resolved target
   output logic          tag_match,
   output bp_pkg::word_t predicted_pc,
   output logic          update_hit
);
   import bp_pkg::*;

   localparam int unsigned ENTRIES = 2 ** `BTB_IDX_SIZE;

   // per entry state
   logic       valid_table  [ENTRIES]; // entry holds a real tag
   tag_t       tag_table    [ENTRIES];
   word_t      target_table [ENTRIES];
   bht_state_t bht          [ENTRIES];

   tag_t       lookup_tag;
   btb_idx_t   lookup_idx;
   tag_t       upd_tag;
   btb_idx_t   upd_idx;
   logic       lookup_taken;
   bht_state_t upd_state;      // counter currently at the update index
   bht_state_t upd_state_next;

   // split both pcs into tag and index
   assign {lookup_tag, lookup_idx} = lookup_pc;
   assign {upd_tag, upd_idx}       = update_pc;

   // lookup side, purely combinational
   assign tag_match    = valid_table[lookup_idx] && (tag_table[lookup_idx] == lookup_tag);
   assign lookup_taken = bht[lookup_idx] inside {weak_taken, strong_taken};
   assign predicted_pc = (tag_match && lookup_taken) ? target_table[lookup_idx]
                                                     : lookup_pc + word_t'(1);

   // second compare, on the resolve pc
   assign update_hit = valid_table[upd_idx] && (tag_table[upd_idx] == upd_tag);
   assign upd_state  = bht[upd_idx];

   // next counter value for the update index
   always_comb begin
      upd_state_next = upd_state;
      if (update_tag && !update_hit) begin
         upd_state_next = bht_state_t'(`BHT_INIT); // fresh install
      end else if (update_taken) begin
         case (upd_state)
            strong_not_taken: upd_state_next = weak_not_taken;
            weak_not_taken:   upd_state_next = weak_taken;
            weak_taken:       upd_state_next = strong_taken;
            default:          upd_state_next = strong_taken; // saturate
         endcase
      end else begin
         case (upd_state)
            strong_taken:     upd_state_next = weak_taken;
            weak_taken:       upd_state_next = weak_not_taken;
            weak_not_taken:   upd_state_next = strong_not_taken;
            default:          upd_state_next = strong_not_taken; // saturate
         endcase
      end
   end

   // table writes land at the end of the resolve cycle
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < ENTRIES; i++) begin
            valid_table[i]  <= 1'b0;
            tag_table[i]    <= '0;
            target_table[i] <= '0;
            bht[i]          <= bht_state_t'(`BHT_INIT);
         end
      end else begin
         if (update_tag) begin
            valid_table[upd_idx]  <= 1'b1;
            tag_table[upd_idx]    <= upd_tag;       // evicts any other tag here
            target_table[upd_idx] <= update_target;
         end
         if (update_bht) begin
            bht[upd_idx] <= upd_state_next;
         end
      end
   end

endmodule

//--- fetch_pc_unit.sv
module fetch_pc_unit (
   input  logic          clk,
   input  logic          reset_n,
   input  logic          fetch_ready,    // decode can take the pc
   input  logic          redirect_valid, // mispredict seen at resolve
   input  bp_pkg::word_t redirect_pc,    // real next pc
   input  bp_pkg::word_t predicted_pc,   // predictor answer for fetch_pc
   output logic          fetch_valid,
   output bp_pkg::word_t fetch_pc,
   output bp_pkg::word_t fetch_pred_pc
);
   import bp_pkg::*;

   logic  valid_q;
   word_t pc_q;
   word_t pc_next;
   logic  xfer; // handshake completes this cycle

   assign xfer = valid_q && fetch_ready;

   // pc source select
   // redirect wins over advance, advance over hold
   always_comb begin
      pc_next = pc_q;
      if (redirect_valid) begin
         pc_next = redirect_pc;
      end else if (xfer) begin
         pc_next = predicted_pc; // successor offered with this pc
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         valid_q <= 1'b0;
         pc_q    <= '0; // fetch starts at 0
      end else begin
         valid_q <= 1'b1; // always something to fetch after reset
         pc_q    <= pc_next;
      end
   end

   assign fetch_valid   = valid_q;
   assign fetch_pc      = pc_q;
   assign fetch_pred_pc = predicted_pc; // lookup is combinational on fetch_pc

endmodule

//--- branch_resolve_unit.sv
module branch_resolve_unit (
   input  logic          clk,
   input  logic          reset_n,
   input  logic          resolve_valid,   // branch outcome this cycle
   input  bp_pkg::word_t resolve_pc,
   input  bp_pkg::word_t resolve_pred_pc, // what fetch guessed
   input  logic          resolve_taken,
   input  bp_pkg::word_t resolve_target,
   input  logic          update_hit,      // tag compare from the predictor
   output logic          update_tag,
   output logic          update_bht,
   output bp_pkg::word_t update_pc,
   output logic          update_taken,
   output bp_pkg::word_t update_target,
   output logic          redirect_valid,
   output bp_pkg::word_t redirect_pc
);
   import bp_pkg::*;

   word_t       real_pc;          // actual successor
   logic        mispredict;
   logic [15:0] mispredict_count; // wraps, watched by the testbench checker

   assign real_pc    = resolve_taken ? resolve_target : resolve_pc + word_t'(1);
   assign mispredict = resolve_valid && (real_pc != resolve_pred_pc);

   // taken always writes tag and target
   // not taken only trains an entry that is already there
   assign update_tag    = resolve_valid && resolve_taken;
   assign update_bht    = resolve_valid && (resolve_taken || update_hit);
   assign update_pc     = resolve_pc;
   assign update_taken  = resolve_taken;
   assign update_target = resolve_target;

   // same-cycle redirect
   assign redirect_valid = mispredict;
   assign redirect_pc    = real_pc;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mispredict_count <= '0;
      end else if (mispredict) begin
         mispredict_count <= mispredict_count + 16'd1;
      end
   end

endmodule

//--- bp_frontend.sv
module bp_frontend (
   input  logic          clk,
   input  logic          reset_n,
   // fetch channel toward decode
   output logic          fetch_valid,
   input  logic          fetch_ready,
   output bp_pkg::word_t fetch_pc,
   output bp_pkg::word_t fetch_pred_pc,
   // resolve channel from the later stage, no ready
   input  logic          resolve_valid,
   input  bp_pkg::word_t resolve_pc,
   input  bp_pkg::word_t resolve_pred_pc,
   input  logic          resolve_taken,
   input  bp_pkg::word_t resolve_target,
   output logic          redirect_valid
);
   import bp_pkg::*;

   word_t predicted_pc;
   logic  update_tag;
   logic  update_bht;
   word_t update_pc;
   logic  update_taken;
   word_t update_target;
   logic  update_hit;
   word_t redirect_pc;

   branch_predictor u_branch_predictor (
      .clk           (clk),
      .reset_n       (reset_n),
      .lookup_pc     (fetch_pc),
      .update_tag    (update_tag),
      .update_bht    (update_bht),
      .update_pc     (update_pc),
      .update_taken  (update_taken),
      .update_target (update_target),
      .tag_match     (), // folded into predicted_pc already
      .predicted_pc  (predicted_pc),
      .update_hit    (update_hit)
   );

   branch_resolve_unit u_branch_resolve_unit (
      .clk             (clk),
      .reset_n         (reset_n),
      .resolve_valid   (resolve_valid),
      .resolve_pc      (resolve_pc),
      .resolve_pred_pc (resolve_pred_pc),
      .resolve_taken   (resolve_taken),
      .resolve_target  (resolve_target),
      .update_hit      (update_hit),
      .update_tag      (update_tag),
      .update_bht      (update_bht),
      .update_pc       (update_pc),
      .update_taken    (update_taken),
      .update_target   (update_target),
      .redirect_valid  (redirect_valid),
      .redirect_pc     (redirect_pc)
   );

   fetch_pc_unit u_fetch_pc_unit (
      .clk            (clk),
      .reset_n        (reset_n),
      .fetch_ready    (fetch_ready),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .predicted_pc   (predicted_pc),
      .fetch_valid    (fetch_valid),
      .fetch_pc       (fetch_pc),
      .fetch_pred_pc  (fetch_pred_pc)
   );

endmodule

//--- bp_frontend_assert.sv
module bp_frontend_assert (
   input  logic          clk,
   input  logic          reset_n,
   input  logic          fetch_valid,
   input  logic          fetch_ready,
   input  bp_pkg::word_t fetch_pc,
   input  bp_pkg::word_t fetch_pred_pc,
   input  logic          resolve_valid,
   input  logic          redirect_valid,
   input  bp_pkg::word_t redirect_pc
);
   import bp_pkg::*;

   int unsigned stall_errors    = 0;
   int unsigned redirect_errors = 0;
   int unsigned reset_errors    = 0;
   int unsigned assert_errors; // total, read by the testbench top

   assign assert_errors = stall_errors + redirect_errors + reset_errors;

   // stalled channel with no resolve, offer must not move
   stall_holds_offer: assert property (@(posedge clk) disable iff (!reset_n)
      fetch_valid && !fetch_ready && !resolve_valid
         |=> $stable(fetch_pc) && $stable(fetch_pred_pc))
      else begin
         stall_errors++;
         $error("fetch offer changed while decode stalled");
      end

   // redirect lands on fetch_pc one cycle later
   redirect_lands: assert property (@(posedge clk) disable iff (!reset_n)
      redirect_valid |=> fetch_pc == $past(redirect_pc))
      else begin
         redirect_errors++;
         $error("fetch_pc did not take the redirect pc");
      end

   // nothing offered to decode while in reset
   reset_idles_fetch: assert property (@(posedge clk) !reset_n |=> !fetch_valid)
      else begin
         reset_errors++;
         $error("fetch_valid high during reset");
      end

endmodule

bind bp_frontend bp_frontend_assert u_assert (
   .clk            (clk),
   .reset_n        (reset_n),
   .fetch_valid    (fetch_valid),
   .fetch_ready    (fetch_ready),
   .fetch_pc       (fetch_pc),
   .fetch_pred_pc  (fetch_pred_pc),
   .resolve_valid  (resolve_valid),
   .redirect_valid (redirect_valid),
   .redirect_pc    (redirect_pc) // internal wire of the top level
);

//--- bp_checker.sv
module bp_checker (
   input  logic          clk,
   input  logic          reset_n,
   input  logic          fetch_valid,
   input  logic          fetch_ready,
   input  bp_pkg::word_t fetch_pc,
   input  bp_pkg::word_t fetch_pred_pc,
   input  logic          redirect_valid,
   input  logic          case_go,      // resolve cycle of a new case
   input  int            case_idx,
   input  bp_pkg::word_t exp_pc,       // expected at the next transfer
   input  bp_pkg::word_t exp_pred_pc,
   input  logic          exp_redirect, // expected in the resolve cycle
   input  logic [15:0]   mispredict_count, // redirects counted inside the DUT
   output int            done_count,
   output int            pass_count,
   output int            fail_count
);
   import bp_pkg::*;

   localparam int MAX_WAIT = 48; // cycles allowed before a transfer

   logic busy;        // case open, waiting for its transfer
   logic case_bad;
   int   wait_cycles;
   logic [15:0] exp_mispredicts; // redirects the case file asked for so far

   task automatic compare_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAIL case %0d: %s got %h expected %h", case_idx, name, got, exp);
         case_bad = 1'b1;
      end
   endtask

   task automatic close_case();
      if (case_bad) begin
         $display("case %0d failed", case_idx);
         fail_count++;
      end else begin
         $display("case %0d ok: fetch_pc %h fetch_pred_pc %h",
                  case_idx, fetch_pc, fetch_pred_pc);
         pass_count++;
      end
      done_count++; // releases the driver
      busy = 1'b0;
   endtask

   // sampled at the edge, before any register in the DUT moves
   always @(posedge clk) begin
      if (!reset_n) begin
         busy            = 1'b0;
         case_bad        = 1'b0;
         wait_cycles     = 0;
         exp_mispredicts = '0;
         done_count      = 0;
         pass_count      = 0;
         fail_count      = 0;
      end else begin
         if (case_go) begin
            busy        = 1'b1;
            case_bad    = 1'b0;
            wait_cycles = 0;
            if (redirect_valid !== exp_redirect) begin
               $display("FAIL case %0d: redirect_valid got %h expected %h",
                        case_idx, redirect_valid, exp_redirect);
               case_bad = 1'b1;
            end
            // counter still holds only the redirects of earlier cases
            if (mispredict_count !== exp_mispredicts) begin
               $display("FAIL case %0d: mispredict_count got %h expected %h",
                        case_idx, mispredict_count, exp_mispredicts);
               case_bad = 1'b1;
            end
            if (exp_redirect) begin
               exp_mispredicts = exp_mispredicts + 16'd1;
            end
         end
         if (busy) begin
            // transfer under a redirect is squashed, not counted
            if (fetch_valid && fetch_ready && !redirect_valid) begin
               compare_word("fetch_pc", fetch_pc, exp_pc);
               compare_word("fetch_pred_pc", fetch_pred_pc, exp_pred_pc);
               close_case();
            end else if (wait_cycles == MAX_WAIT) begin
               $display("case %0d: decode received no pc within %0d cycles",
                        case_idx, MAX_WAIT);
               case_bad = 1'b1;
               close_case();
            end else begin
               wait_cycles++;
            end
         end
      end
   end

endmodule

//--- bp_frontend_tb.sv
module bp_frontend_tb;
   import bp_pkg::*;

   localparam int FIELDS          = 9;  // columns per case line
   localparam int MAX_CASES       = 128;
   localparam int CYCLES_PER_CASE = 64;

   logic  clk;
   logic  reset_n;
   logic  fetch_valid;
   logic  fetch_ready;
   word_t fetch_pc;
   word_t fetch_pred_pc;
   logic  resolve_valid;
   word_t resolve_pc;
   word_t resolve_pred_pc;
   logic  resolve_taken;
   word_t resolve_target;
   logic  redirect_valid;

   logic  case_go;
   int    case_idx;
   word_t exp_pc;
   word_t exp_pred_pc;
   logic  exp_redirect;
   int    done_count;
   int    pass_count;
   int    fail_count;

   word_t  case_mem [FIELDS*MAX_CASES];
   int     num_cases;
   logic   loaded;
   integer seed;

   bp_frontend u_bp_frontend (
      .clk             (clk),
      .reset_n         (reset_n),
      .fetch_valid     (fetch_valid),
      .fetch_ready     (fetch_ready),
      .fetch_pc        (fetch_pc),
      .fetch_pred_pc   (fetch_pred_pc),
      .resolve_valid   (resolve_valid),
      .resolve_pc      (resolve_pc),
      .resolve_pred_pc (resolve_pred_pc),
      .resolve_taken   (resolve_taken),
      .resolve_target  (resolve_target),
      .redirect_valid  (redirect_valid)
   );

   bp_checker u_bp_checker (
      .clk            (clk),
      .reset_n        (reset_n),
      .fetch_valid    (fetch_valid),
      .fetch_ready    (fetch_ready),
      .fetch_pc       (fetch_pc),
      .fetch_pred_pc  (fetch_pred_pc),
      .redirect_valid (redirect_valid),
      .case_go        (case_go),
      .case_idx       (case_idx),
      .exp_pc         (exp_pc),
      .exp_pred_pc    (exp_pred_pc),
      .exp_redirect   (exp_redirect),
      .mispredict_count (u_bp_frontend.u_branch_resolve_unit.mispredict_count),
      .done_count     (done_count),
      .pass_count     (pass_count),
      .fail_count     (fail_count)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk; // period 8
      end
   end

   task automatic load_cases();
      for (int i = 0; i < FIELDS * MAX_CASES; i++) begin
         case_mem[i] = 16'hf000 | word_t'(i); // never a legal valid column
      end
      $readmemh("bp_cases.txt", case_mem);
      num_cases = 0;
      while (num_cases < MAX_CASES && case_mem[num_cases * FIELDS] <= 16'h0001) begin
         num_cases++;
      end
   endtask

   // entered 1 after a rising edge, leaves 1 after the edge that closed the case
   task automatic run_case(input int idx);
      int          base;
      logic [31:0] rnd;
      base            = idx * FIELDS;
      resolve_valid   = case_mem[base][0];
      resolve_pc      = case_mem[base+1];
      resolve_pred_pc = case_mem[base+2];
      resolve_taken   = case_mem[base+3][0];
      resolve_target  = case_mem[base+4];
      fetch_ready     = case_mem[base+5][0];
      exp_pc          = case_mem[base+6];
      exp_pred_pc     = case_mem[base+7];
      exp_redirect    = case_mem[base+8][0];
      case_idx        = idx;
      case_go         = 1'b1;
      @(posedge clk);
      #1;
      case_go       = 1'b0;
      resolve_valid = 1'b0; // resolve lasts one cycle
      while (done_count <= idx) begin
         rnd         = $random(seed);
         fetch_ready = rnd[1:0] != 2'b00; // ready three cycles in four
         @(posedge clk);
         #1;
      end
   endtask

   initial begin
      reset_n         = 1'b0;
      fetch_ready     = 1'b0;
      resolve_valid   = 1'b0;
      resolve_pc      = '0;
      resolve_pred_pc = '0;
      resolve_taken   = 1'b0;
      resolve_target  = '0;
      case_go         = 1'b0;
      case_idx        = 0;
      exp_pc          = '0;
      exp_pred_pc     = '0;
      exp_redirect    = 1'b0;
      seed            = 32'hb07b7c66;
      loaded          = 1'b0;
      load_cases();
      loaded = 1'b1;
      repeat (4) @(posedge clk);
      #1 reset_n = 1'b1;
      for (int i = 0; i < num_cases; i++) begin
         run_case(i);
      end
      repeat (2) @(posedge clk); // last redirect check settles
      $display("summary: %0d cases, %0d passed, %0d failed, %0d assertion failures",
               num_cases, pass_count, fail_count, u_bp_frontend.u_assert.assert_errors);
      if (num_cases > 0 && fail_count == 0 && done_count == num_cases &&
          u_bp_frontend.u_assert.assert_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // watchdog, budget grows with the case count
   initial begin
      wait (loaded);
      repeat ((num_cases + 1) * CYCLES_PER_CASE) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles",
               (num_cases + 1) * CYCLES_PER_CASE);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- bp_frontend.f
+incdir+.
bp_pkg.sv
branch_predictor.sv
fetch_pc_unit.sv
branch_resolve_unit.sv
bp_frontend.sv
bp_frontend_assert.sv
bp_checker.sv
bp_frontend_tb.sv

//--- Makefile
TOP = bp_frontend_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f bp_frontend.f --top-module $(TOP)

sim:
	verilator --binary --assert -j 0 -f bp_frontend.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed, see sim.log"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "simulation did not finish, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- bp_cases.txt
// valid resolve_pc resolve_pred_pc taken resolve_target fetch_ready
// then expected fetch_pc, fetch_pred_pc at the next transfer, expected redirect
0 0000 0000 0 0000 1 0000 0001 0
0 0000 0000 0 0000 1 0001 0002 0
0 0000 0000 0 0000 1 0002 0003 0
1 0010 0011 1 0040 0 0040 0041 1
1 000f 0040 0 0000 0 0010 0040 1
1 0010 0040 0 0040 0 0011 0012 1
1 000f 0040 0 0000 0 0010 0011 1
1 0010 0011 1 0040 0 0040 0041 1
1 0010 0040 1 0040 1 0041 0042 0
1 0010 0040 0 0040 0 0011 0012 1
1 000f 0040 0 0000 0 0010 0040 1
1 0050 0051 1 0080 0 0080 0081 1
1 000f 0040 0 0000 0 0010 0011 1
1 004f 0040 0 0000 0 0050 0080 1
1 0030 0031 0 0000 1 0080 0081 0
0 0000 0000 0 0000 0 0081 0082 0
0 0000 0000 0 0000 0 0082 0083 0
0 0000 0000 0 0000 0 0083 0084 0
